// File: hdl/conv_cfg_pkg.sv
package conv_cfg_pkg;

    // Default image and kernel geometry
    localparam int DEF_PIC_BITS    = 2;  // Unsigned pixel width
    localparam int DEF_WEIGHT_BITS = 3;  // Two's complement weight width
    localparam int DEF_KERNEL_SIZE = 5;  // Kernel side, odd
    localparam int DEF_PIC_SIZE    = 28; // Square image side

    // APB register map
    localparam int APB_ADDR_BITS = 12;
    localparam int APB_DATA_BITS = 32;
    localparam logic [APB_ADDR_BITS-1:0] STATUS_ADDR = 12'h100; // Read only, bit 0 busy

    // Signed accumulator width for K*K products plus sign bit
    function automatic int result_bits(int pic_bits, int weight_bits, int kernel_size);
        return pic_bits + weight_bits + $clog2(kernel_size * kernel_size) + 1;
    endfunction

endpackage

// File: hdl/conv_types_pkg.sv
package conv_types_pkg;

    // Run sequencer states, one pass per input row
    typedef enum logic [2:0] {
        IDLE,  // Waiting for conv_start
        SHIFT, // Rows move up, bottom row zeroed
        LOAD,  // Bottom row filled from pixel port
        CALC   // One window per cycle into the PE
    } conv_state_e;

    // Decoded target of an APB access
    typedef enum logic [1:0] {
        REG_WEIGHT,  // Kernel weight at paddr / 4
        REG_STATUS,  // Status register
        REG_INVALID  // Unmapped or misaligned
    } apb_reg_e;

endpackage

// File: hdl/conv_ctrl_if.sv
`timescale 1ns/100ps

interface conv_ctrl_if
    import conv_cfg_pkg::*;
#(
    parameter int PIC_SIZE    = DEF_PIC_SIZE,
    parameter int KERNEL_SIZE = DEF_KERNEL_SIZE
) ();
    localparam int COL_BITS  = $clog2(PIC_SIZE);
    localparam int ROW_BITS  = $clog2(PIC_SIZE + KERNEL_SIZE / 2 + 1); // Room for pad rows
    localparam int ADDR_BITS = $clog2(PIC_SIZE * PIC_SIZE);

    logic                 clear;     // Restart counters and line buffer
    logic                 shift_row; // Move buffer rows up
    logic                 load_en;   // Pixel accepted this cycle
    logic                 calc_en;   // Window issued to PE this cycle

    logic [ROW_BITS-1:0]  in_row;    // Input row being processed
    logic [COL_BITS-1:0]  col;       // Pixel or window column
    logic [ADDR_BITS-1:0] out_addr;  // Raster address of next window
    logic                 prime_row; // Row only fills the buffer
    logic                 pad_row;   // Below the image, no pixels
    logic                 col_last;  // Column at PIC_SIZE-1
    logic                 last_row;  // Row yields last output row

    modport fsm (output clear, shift_row, load_en, calc_en,
                 input  prime_row, pad_row, col_last, last_row);
    modport cnt (input  clear, load_en, calc_en,
                 output in_row, col, out_addr, prime_row, pad_row, col_last, last_row);
    modport lbuf (input clear, shift_row, load_en, col);

endinterface

// File: hdl/conv_fsm.sv
`timescale 1ns/100ps

module conv_fsm
    import conv_types_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     conv_start,
    input  logic     pic_valid,
    output logic     need_pic,
    output logic     busy,
    conv_ctrl_if.fsm ctrl
);

    conv_state_e state;
    conv_state_e state_n;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_n;
        end
    end

    assign need_pic       = (state == LOAD);             // Request pixels of current row
    assign busy           = (state != IDLE);
    assign ctrl.clear     = (state == IDLE) && conv_start; // Start only taken when idle
    assign ctrl.shift_row = (state == SHIFT);
    assign ctrl.load_en   = need_pic && pic_valid;       // Handshake on the pixel port
    assign ctrl.calc_en   = (state == CALC);

    // Row sequence is SHIFT, then LOAD unless padding, then CALC unless priming
    always_comb begin
        state_n = state;
        case (state)
            IDLE: begin
                if (conv_start) begin
                    state_n = SHIFT;
                end
            end
            SHIFT: begin
                if (ctrl.pad_row) begin
                    state_n = CALC; // Bottom row stays zero
                end else begin
                    state_n = LOAD;
                end
            end
            LOAD: begin
                if (ctrl.load_en && ctrl.col_last) begin
                    if (ctrl.prime_row) begin
                        state_n = SHIFT; // Not enough rows for a window yet
                    end else begin
                        state_n = CALC;
                    end
                end
            end
            CALC: begin
                if (ctrl.col_last) begin
                    if (ctrl.last_row) begin
                        state_n = IDLE; // Last output row issued
                    end else begin
                        state_n = SHIFT;
                    end
                end
            end
            default: begin
                state_n = IDLE;
            end
        endcase
    end

endmodule

// File: hdl/conv_pos_counter.sv
`timescale 1ns/100ps

module conv_pos_counter
    import conv_cfg_pkg::*;
#(
    parameter int PIC_SIZE    = DEF_PIC_SIZE,
    parameter int KERNEL_SIZE = DEF_KERNEL_SIZE
) (
    input  logic     clk,
    input  logic     rst_n,
    conv_ctrl_if.cnt ctrl
);

    localparam int COL_BITS = $clog2(PIC_SIZE);
    localparam int ROW_BITS = $clog2(PIC_SIZE + KERNEL_SIZE / 2 + 1);
    localparam int HALF     = KERNEL_SIZE / 2; // Padding on each side

    logic step;     // Column advances
    logic row_done; // Last action of the current row

    assign step     = ctrl.load_en || ctrl.calc_en;
    assign row_done = ctrl.col_last && (ctrl.calc_en || (ctrl.load_en && ctrl.prime_row));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl.col      <= '0;
            ctrl.in_row   <= '0;
            ctrl.out_addr <= '0;
        end else if (ctrl.clear) begin
            ctrl.col      <= '0;
            ctrl.in_row   <= '0;
            ctrl.out_addr <= '0;
        end else begin
            if (step) begin
                ctrl.col <= ctrl.col_last ? '0 : ctrl.col + 1'b1; // Wrap at PIC_SIZE
            end
            if (row_done) begin
                ctrl.in_row <= ctrl.in_row + 1'b1;
            end
            if (ctrl.calc_en) begin
                ctrl.out_addr <= ctrl.out_addr + 1'b1; // Raster order
            end
        end
    end

    assign ctrl.col_last  = (ctrl.col == COL_BITS'(PIC_SIZE - 1));
    assign ctrl.prime_row = (ctrl.in_row < ROW_BITS'(HALF));
    assign ctrl.pad_row   = (ctrl.in_row >= ROW_BITS'(PIC_SIZE));
    assign ctrl.last_row  = (ctrl.in_row == ROW_BITS'(PIC_SIZE + HALF - 1));

endmodule

// File: hdl/line_buffer.sv
`timescale 1ns/100ps

module line_buffer
    import conv_cfg_pkg::*;
#(
    parameter int PIC_BITS    = DEF_PIC_BITS,
    parameter int PIC_SIZE    = DEF_PIC_SIZE,
    parameter int KERNEL_SIZE = DEF_KERNEL_SIZE
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [PIC_BITS-1:0] pic,
    output logic [PIC_BITS-1:0] window [KERNEL_SIZE * KERNEL_SIZE], // Row major, top row first
    conv_ctrl_if.lbuf           ctrl
);

    localparam int HALF    = KERNEL_SIZE / 2;
    localparam int ROW_LEN = PIC_SIZE + 2 * HALF; // Image row plus zero margins

    // Row 0 holds the oldest input row, row KERNEL_SIZE-1 the newest
    logic [PIC_BITS-1:0] rows [KERNEL_SIZE][ROW_LEN];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rows <= '{default: '0};
        end else if (ctrl.clear) begin
            rows <= '{default: '0}; // Also zeroes the margins
        end else if (ctrl.shift_row) begin
            for (int r = 0; r < KERNEL_SIZE - 1; r++) begin
                rows[r] <= rows[r + 1];
            end
            rows[KERNEL_SIZE - 1] <= '{default: '0}; // Fresh row, padding if not loaded
        end else if (ctrl.load_en) begin
            rows[KERNEL_SIZE - 1][int'(ctrl.col) + HALF] <= pic; // Skip left margin
        end
    end

    // Window whose leftmost buffer column is col, centred on image column col
    always_comb begin
        for (int r = 0; r < KERNEL_SIZE; r++) begin
            for (int c = 0; c < KERNEL_SIZE; c++) begin
                window[r * KERNEL_SIZE + c] = rows[r][int'(ctrl.col) + c];
            end
        end
    end

endmodule

// File: hdl/weight_regs.sv
`timescale 1ns/100ps

module weight_regs
    import conv_cfg_pkg::*;
    import conv_types_pkg::*;
#(
    parameter int WEIGHT_BITS = DEF_WEIGHT_BITS,
    parameter int KERNEL_SIZE = DEF_KERNEL_SIZE
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [APB_ADDR_BITS-1:0]      paddr,
    input  logic [APB_DATA_BITS-1:0]      pwdata,
    input  logic                          busy,
    output logic [APB_DATA_BITS-1:0]      prdata,
    output logic                          pready,
    output logic                          pslverr,
    output logic signed [WEIGHT_BITS-1:0] weights [KERNEL_SIZE * KERNEL_SIZE]
);

    localparam int KK       = KERNEL_SIZE * KERNEL_SIZE;
    localparam int IDX_BITS = $clog2(KK);

    logic [APB_ADDR_BITS-3:0]      word_addr; // Byte address over four
    logic [IDX_BITS-1:0]           widx;      // Weight index
    logic signed [WEIGHT_BITS-1:0] rd_weight;
    apb_reg_e                      reg_sel;
    logic                          access;    // Enable phase
    logic                          err;
    logic                          wr_weight;

    assign word_addr = paddr[APB_ADDR_BITS-1:2];
    assign widx      = word_addr[IDX_BITS-1:0];
    assign rd_weight = weights[widx];
    assign access    = psel && penable;

    always_comb begin
        if (paddr == STATUS_ADDR) begin
            reg_sel = REG_STATUS;
        end else if (paddr[1:0] == 2'b00 && word_addr < (APB_ADDR_BITS - 2)'(KK)) begin
            reg_sel = REG_WEIGHT;
        end else begin
            reg_sel = REG_INVALID;
        end
    end

    // Unmapped access, status write, or weight write during a run
    assign err       = access && (reg_sel == REG_INVALID ||
                                  (pwrite && (reg_sel == REG_STATUS || busy)));
    assign wr_weight = access && pwrite && !err && (reg_sel == REG_WEIGHT);
    assign pslverr   = err;
    assign pready    = 1'b1; // No wait states

    always_comb begin
        prdata = '0; // Also the value on error
        if (access && !pwrite && !err) begin
            case (reg_sel)
                REG_WEIGHT: prdata = {{(APB_DATA_BITS - WEIGHT_BITS){rd_weight[WEIGHT_BITS-1]}},
                                      rd_weight}; // Sign extended
                REG_STATUS: prdata = {{(APB_DATA_BITS - 1){1'b0}}, busy};
                default:    prdata = '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weights <= '{default: '0};
        end else if (wr_weight) begin
            weights[widx] <= pwdata[WEIGHT_BITS-1:0]; // Low bits only
        end
    end

endmodule

// File: hdl/conv_pe.sv
`timescale 1ns/100ps

module conv_pe
    import conv_cfg_pkg::*;
#(
    parameter int PIC_BITS    = DEF_PIC_BITS,
    parameter int WEIGHT_BITS = DEF_WEIGHT_BITS,
    parameter int KERNEL_SIZE = DEF_KERNEL_SIZE,
    parameter int PIC_SIZE    = DEF_PIC_SIZE
) (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic [PIC_BITS-1:0]                        window [KERNEL_SIZE * KERNEL_SIZE],
    input  logic signed [WEIGHT_BITS-1:0]              weights [KERNEL_SIZE * KERNEL_SIZE],
    input  logic                                       calc_en,
    input  logic [$clog2(PIC_SIZE * PIC_SIZE)-1:0]     out_addr,
    input  logic                                       last_row,
    input  logic                                       col_last,
    output logic signed
        [result_bits(PIC_BITS, WEIGHT_BITS, KERNEL_SIZE)-1:0] conv_result,
    output logic                                       conv_result_valid,
    output logic [$clog2(PIC_SIZE * PIC_SIZE)-1:0]     conv_result_addr,
    output logic                                       conv_finish
);

    localparam int KK        = KERNEL_SIZE * KERNEL_SIZE;
    localparam int PROD_BITS = PIC_BITS + WEIGHT_BITS; // Unsigned times signed fits here
    localparam int RES_BITS  = result_bits(PIC_BITS, WEIGHT_BITS, KERNEL_SIZE);
    localparam int ADDR_BITS = $clog2(PIC_SIZE * PIC_SIZE);

    logic signed [PROD_BITS-1:0] prod_q [KK]; // Stage 1 products
    logic                        valid_q;
    logic                        last_q;
    logic [ADDR_BITS-1:0]        addr_q;
    logic signed [RES_BITS-1:0]  sum;         // Adder tree into stage 2

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q           <= 1'b0;
            last_q            <= 1'b0;
            conv_result_valid <= 1'b0;
            conv_finish       <= 1'b0;
        end else begin
            valid_q           <= calc_en;
            last_q            <= calc_en && last_row && col_last; // Final window of the image
            conv_result_valid <= valid_q;
            conv_finish       <= last_q;
        end
    end

    always_ff @(posedge clk) begin
        if (calc_en) begin
            for (int i = 0; i < KK; i++) begin
                prod_q[i] <= $signed({1'b0, window[i]}) * weights[i]; // Pixel zero extended
            end
            addr_q <= out_addr;
        end
        if (valid_q) begin
            conv_result      <= sum;
            conv_result_addr <= addr_q;
        end
    end

    always_comb begin
        sum = '0;
        for (int i = 0; i < KK; i++) begin
            sum = sum + prod_q[i]; // Sign extended to RES_BITS
        end
    end

endmodule

// File: hdl/conv_top.sv
`timescale 1ns/100ps

module conv_top
    import conv_cfg_pkg::*;
#(
    parameter int PIC_BITS    = DEF_PIC_BITS,
    parameter int WEIGHT_BITS = DEF_WEIGHT_BITS,
    parameter int KERNEL_SIZE = DEF_KERNEL_SIZE,
    parameter int PIC_SIZE    = DEF_PIC_SIZE
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   psel,
    input  logic                                   penable,
    input  logic                                   pwrite,
    input  logic [APB_ADDR_BITS-1:0]               paddr,
    input  logic [APB_DATA_BITS-1:0]               pwdata,
    output logic [APB_DATA_BITS-1:0]               prdata,
    output logic                                   pready,
    output logic                                   pslverr,
    input  logic                                   conv_start,
    input  logic [PIC_BITS-1:0]                    pic,
    input  logic                                   pic_valid,
    output logic                                   need_pic,
    output logic signed
        [result_bits(PIC_BITS, WEIGHT_BITS, KERNEL_SIZE)-1:0] conv_result,
    output logic                                   conv_result_valid,
    output logic [$clog2(PIC_SIZE * PIC_SIZE)-1:0] conv_result_addr,
    output logic                                   conv_finish
);

    localparam int KK = KERNEL_SIZE * KERNEL_SIZE;

    logic                          busy;        // Run in progress
    logic [PIC_BITS-1:0]           window [KK];
    logic signed [WEIGHT_BITS-1:0] weights [KK];

    conv_ctrl_if #(.PIC_SIZE(PIC_SIZE), .KERNEL_SIZE(KERNEL_SIZE)) ctrl_if_i ();

    conv_fsm fsm_i (
        .clk(clk), .rst_n(rst_n), .conv_start(conv_start), .pic_valid(pic_valid),
        .need_pic(need_pic), .busy(busy), .ctrl(ctrl_if_i.fsm)
    );

    conv_pos_counter #(.PIC_SIZE(PIC_SIZE), .KERNEL_SIZE(KERNEL_SIZE)) cnt_i (
        .clk(clk), .rst_n(rst_n), .ctrl(ctrl_if_i.cnt)
    );

    line_buffer #(.PIC_BITS(PIC_BITS), .PIC_SIZE(PIC_SIZE), .KERNEL_SIZE(KERNEL_SIZE)) lbuf_i (
        .clk(clk), .rst_n(rst_n), .pic(pic), .window(window), .ctrl(ctrl_if_i.lbuf)
    );

    weight_regs #(.WEIGHT_BITS(WEIGHT_BITS), .KERNEL_SIZE(KERNEL_SIZE)) wregs_i (
        .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .busy(busy), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .weights(weights)
    );

    // Tags taken straight from the counter alongside calc_en
    conv_pe #(.PIC_BITS(PIC_BITS), .WEIGHT_BITS(WEIGHT_BITS),
              .KERNEL_SIZE(KERNEL_SIZE), .PIC_SIZE(PIC_SIZE)) pe_i (
        .clk(clk), .rst_n(rst_n), .window(window), .weights(weights),
        .calc_en(ctrl_if_i.calc_en), .out_addr(ctrl_if_i.out_addr),
        .last_row(ctrl_if_i.last_row), .col_last(ctrl_if_i.col_last),
        .conv_result(conv_result), .conv_result_valid(conv_result_valid),
        .conv_result_addr(conv_result_addr), .conv_finish(conv_finish)
    );

endmodule

// File: testbench/tb_conv_tasks.svh
task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "Stopped at first error");
endtask

task automatic check_value(input string test, input string what, input longint exp,
                           input longint act);
    assert (exp == act) else begin
        $display("FAIL %s %s expected %0d actual %0d", test, what, exp, act);
        $display("=== FAIL ===");
        $fatal(1, "Stopped at first error");
    end
endtask

function automatic int rand_weight();
    int r;
    r = $random(seed) & ((1 << WEIGHT_BITS) - 1);
    return (r >= (1 << (WEIGHT_BITS - 1))) ? r - (1 << WEIGHT_BITS) : r; // Two's complement
endfunction

task automatic fill_image();
    for (int i = 0; i < NPIX; i++) begin
        img[i] = $random(seed) & ((1 << PIC_BITS) - 1);
    end
endtask

// Setup phase then enable phase sampled midway
task automatic apb_access(input bit write, input int addr, input int wdata,
                          output logic [APB_DATA_BITS-1:0] rdata, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = APB_ADDR_BITS'(addr);
    pwdata  = APB_DATA_BITS'(wdata);
    @(negedge clk);
    penable = 1'b1;
    #(CLK_PERIOD / 4);
    assert (pready) else stop_with_error("APB slave inserted a wait state"); // Zero wait states
    rdata = prdata;
    err   = pslverr;
    @(negedge clk); // Completed on the rising edge in between
    psel    = 1'b0;
    penable = 1'b0;
endtask

task automatic write_weights(input string test);
    logic [APB_DATA_BITS-1:0] data;
    logic                     err;
    for (int i = 0; i < KK; i++) begin
        apb_access(1'b1, i * 4, wgt[i], data, err);
        check_value(test, $sformatf("pslverr writing weight %0d", i), 0, err);
    end
endtask

task automatic check_weights(input string test);
    logic [APB_DATA_BITS-1:0] data;
    logic                     err;
    for (int i = 0; i < KK; i++) begin
        apb_access(1'b0, i * 4, 0, data, err);
        check_value(test, $sformatf("pslverr reading weight %0d", i), 0, err);
        check_value(test, $sformatf("weight %0d", i), wgt[i], $signed(data)); // Sign extended
    end
endtask

task automatic wait_idle(input string test);
    logic [APB_DATA_BITS-1:0] data;
    logic                     err;
    int                       polls;
    polls = 0;
    data  = '1;
    while (data[0]) begin // Poll status busy bit
        apb_access(1'b0, STATUS_ADDR, 0, data, err);
        check_value(test, "pslverr on status read", 0, err);
        polls++;
        assert (polls < TIMEOUT) else stop_with_error({test, ": busy never cleared"});
    end
endtask

task automatic drive_image(input string test, input bit stall);
    int idx;
    int idle;
    bit valid;
    idx  = 0;
    idle = 0;
    while (idx < NPIX) begin
        @(negedge clk);
        valid     = !stall || (($random(seed) & 3) != 0); // Gaps on one cycle in four
        pic       = PIC_BITS'(img[idx]);
        pic_valid = valid;
        if (need_pic && valid) begin // Taken on the coming rising edge
            idx++;
            idle = 0;
        end else begin
            idle++;
            assert (idle < TIMEOUT) else stop_with_error({test, ": DUT stopped taking pixels"});
        end
    end
    @(negedge clk);
    pic_valid = 1'b0;
endtask

task automatic collect_results(input string test);
    int count;
    int idle;
    count = 0;
    idle  = 0;
    while (1) begin
        @(negedge clk); // Outputs settled since the rising edge
        idle++;
        assert (idle < TIMEOUT) else stop_with_error({test, ": results stopped arriving"});
        if (conv_result_valid) begin
            check_value(test, "result address", count, conv_result_addr); // Raster order
            check_value(test, $sformatf("result at address %0d", count), expected[count],
                        conv_result);
            count++;
            idle = 0;
        end
        if (conv_finish) begin
            assert (conv_result_valid)
                else stop_with_error({test, ": conv_finish without a result"});
            check_value(test, "result count at conv_finish", NPIX, count);
            break;
        end
    end
    repeat (2) begin
        @(negedge clk);
        assert (!conv_result_valid && !conv_finish)
            else stop_with_error({test, ": output seen after conv_finish"});
    end
endtask

task automatic probe_busy(input string test);
    logic [APB_DATA_BITS-1:0] data;
    logic                     err;
    int                       waits;
    waits = 0;
    while (!need_pic) begin // First row being loaded
        @(negedge clk);
        waits++;
        assert (waits < TIMEOUT) else stop_with_error({test, ": need_pic never rose"});
    end
    apb_access(1'b0, STATUS_ADDR, 0, data, err);
    check_value(test, "status during run", 1, data);
    apb_access(1'b1, 0, (wgt[0] == 1) ? 2 : 1, data, err);
    check_value(test, "pslverr on weight write while busy", 1, err);
    @(negedge clk);
    conv_start = 1'b1; // Ignored mid run
    @(negedge clk);
    conv_start = 1'b0;
endtask

task automatic run_image(input string test, input bit stall, input bit probe);
    @(negedge clk);
    conv_start = 1'b1;
    @(negedge clk);
    conv_start = 1'b0;
    fork
        drive_image(test, stall);
        collect_results(test);
        if (probe) probe_busy(test);
    join
endtask

// File: testbench/tb_conv_top.sv
`timescale 1ns/100ps

module tb_conv_top
    import conv_cfg_pkg::*;
();

    localparam int CLK_PERIOD  = 100;  // ns
    localparam int TIMEOUT     = 2000; // Cycles allowed per wait
    localparam int PIC_SIZE    = 8;    // Shrunk image
    localparam int PIC_BITS    = DEF_PIC_BITS;
    localparam int WEIGHT_BITS = DEF_WEIGHT_BITS;
    localparam int KSIZE       = DEF_KERNEL_SIZE;
    localparam int KK          = KSIZE * KSIZE;
    localparam int HALF        = KSIZE / 2;
    localparam int NPIX        = PIC_SIZE * PIC_SIZE;
    localparam int RES_BITS    = PIC_BITS + WEIGHT_BITS + $clog2(KK) + 1;

    logic                       clk, rst_n;
    logic                       psel, penable, pwrite;
    logic [APB_ADDR_BITS-1:0]   paddr;
    logic [APB_DATA_BITS-1:0]   pwdata, prdata;
    logic                       pready, pslverr;
    logic                       conv_start, pic_valid, need_pic;
    logic [PIC_BITS-1:0]        pic;
    logic signed [RES_BITS-1:0] conv_result;
    logic                       conv_result_valid, conv_finish;
    logic [$clog2(NPIX)-1:0]    conv_result_addr;

    integer seed;            // $random state
    int     img [NPIX];      // Image in raster order
    int     wgt [KK];        // Kernel in row major order
    int     expected [NPIX]; // Reference result per address

    conv_top #(.PIC_SIZE(PIC_SIZE)) conv_top_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    `include "tb_conv_tasks.svh"

    // Reference model as neighbourhood sum with zero padding
    task automatic compute_expected();
        int acc;
        int rr;
        int cc;
        for (int r = 0; r < PIC_SIZE; r++) begin
            for (int c = 0; c < PIC_SIZE; c++) begin
                acc = 0;
                for (int i = 0; i < KK; i++) begin
                    rr = r + i / KSIZE - HALF; // Neighbour row
                    cc = c + i % KSIZE - HALF; // Neighbour column
                    if (rr >= 0 && rr < PIC_SIZE && cc >= 0 && cc < PIC_SIZE) begin
                        acc += img[rr * PIC_SIZE + cc] * wgt[i];
                    end
                end
                expected[r * PIC_SIZE + c] = acc;
            end
        end
    endtask

    task automatic test_reset_apb();
        string                    t = "test_reset_apb";
        logic [APB_DATA_BITS-1:0] data;
        logic                     err;
        check_value(t, "need_pic", 0, need_pic);
        check_value(t, "conv_result_valid", 0, conv_result_valid);
        check_value(t, "conv_finish", 0, conv_finish);
        check_value(t, "pslverr", 0, pslverr);
        apb_access(1'b0, STATUS_ADDR, 0, data, err);
        check_value(t, "status", 0, data);
        check_value(t, "pslverr on status read", 0, err);
        check_weights(t); // All zero out of reset
        for (int i = 0; i < KK; i++) begin
            wgt[i] = rand_weight();
        end
        write_weights(t);
        check_weights(t);
    endtask

    task automatic test_apb_errors();
        string                    t = "test_apb_errors";
        logic [APB_DATA_BITS-1:0] data;
        logic                     err;
        int                       alias_addr;
        alias_addr = (1 << $clog2(KK)) * 4; // Unmapped word sharing index bits with weight 0
        apb_access(1'b1, STATUS_ADDR, wgt[0] + 1, data, err);
        check_value(t, "pslverr on status write", 1, err);
        check_value(t, "prdata on status write", 0, data);
        apb_access(1'b1, KK * 4, 3, data, err); // First word past the kernel
        check_value(t, "pslverr on unmapped write", 1, err);
        apb_access(1'b1, alias_addr, wgt[0] + 1, data, err);
        check_value(t, "pslverr on aliased write", 1, err);
        apb_access(1'b0, KK * 4, 0, data, err);
        check_value(t, "pslverr on unmapped read", 1, err);
        check_value(t, "prdata on unmapped read", 0, data);
        check_weights(t);
    endtask

    task automatic test_identity();
        for (int i = 0; i < KK; i++) begin
            wgt[i] = 0;
        end
        wgt[HALF * KSIZE + HALF] = 1; // Centre tap only
        write_weights("test_identity");
        fill_image();
        expected = img; // Output equals input pixel
        run_image("test_identity", 1'b0, 1'b0);
    endtask

    task automatic test_random_conv();
        for (int i = 0; i < KK; i++) begin
            wgt[i] = rand_weight();
        end
        write_weights("test_random_conv");
        fill_image();
        compute_expected();
        run_image("test_random_conv", 1'b1, 1'b0);
    endtask

    task automatic test_busy();
        fill_image();
        compute_expected();
        run_image("test_busy", 1'b0, 1'b1);
        wait_idle("test_busy");
        check_weights("test_busy"); // Write during run not applied
    endtask

    task automatic test_back_to_back();
        fill_image();
        compute_expected();
        run_image("test_back_to_back", 1'b0, 1'b0);
        wait_idle("test_back_to_back");
        fill_image(); // Second image started as soon as idle
        compute_expected();
        run_image("test_back_to_back", 1'b0, 1'b0);
    endtask

    initial begin
        seed       = 50;
        clk        = 1'b0;
        rst_n      = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        conv_start = 1'b0;
        pic        = '0;
        pic_valid  = 1'b0;
        repeat (3) @(posedge clk); // Reset held three cycles
        @(negedge clk);
        rst_n = 1'b1;
        test_reset_apb();
        test_apb_errors();
        test_identity();
        test_random_conv();
        test_busy();
        test_back_to_back();
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: sources.f
+incdir+testbench
hdl/conv_cfg_pkg.sv
hdl/conv_types_pkg.sv
hdl/conv_ctrl_if.sv
hdl/conv_fsm.sv
hdl/conv_pos_counter.sv
hdl/line_buffer.sv
hdl/weight_regs.sv
hdl/conv_pe.sv
hdl/conv_top.sv
testbench/tb_conv_top.sv

// File: Makefile
SIM      := verilator
TOP      := tb_conv_top
FILELIST := sources.f
FLAGS    := --binary --timing -Wno-fatal
OBJ_DIR  := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf $(OBJ_DIR)
